// File: source/sense_ctl_pkg.sv
/*
  sense controller shared definitions
  register map, mode codes, frame layout and the conditioning word
*/
`default_nettype none

package sense_ctl_pkg;

  // widths
  localparam int COND_BITS  = 29;
  localparam int REG_BITS   = 32;
  localparam int ADDR_BITS  = 7;
  localparam int FRAME_BITS = 40;
  localparam int MODE_BITS  = 3;

  // register addresses, low 7 bits of the first frame byte
  localparam logic [ADDR_BITS-1:0] ADDR_LED     = 7'd7;
  localparam logic [ADDR_BITS-1:0] ADDR_SPI_MUX = 7'd8;
  localparam logic [ADDR_BITS-1:0] ADDR_4094    = 7'd9;
  localparam logic [ADDR_BITS-1:0] ADDR_MODE    = 7'd12;
  localparam logic [ADDR_BITS-1:0] ADDR_DIRECT  = 7'd14;

  // output modes
  localparam logic [MODE_BITS-1:0] MODE_LED_ONLY = 3'd0;
  localparam logic [MODE_BITS-1:0] MODE_ALL_ONES = 3'd1;
  localparam logic [MODE_BITS-1:0] MODE_PATTERN  = 3'd2;
  localparam logic [MODE_BITS-1:0] MODE_DIRECT   = 3'd3;

  // conditioning outputs, msb first, azmux sits at bit 0
  typedef struct packed {
    logic       spi_interrupt;
    logic       meas_complete;
    logic       cmpr_latch;
    logic [3:0] adcmux;
    logic [7:0] monitor;
    logic       led0;
    logic       sig_pc_sw;
    logic [3:0] himux2;
    logic [3:0] himux;
    logic [3:0] azmux;
  } cond_fields_t;

  // same 29 bits, seen either as a flat word or as fields
  typedef union packed {
    logic [COND_BITS-1:0] raw;
    cond_fields_t         f;
  } cond_word_t;

endpackage

`default_nettype wire

// File: source/spi_sampler.sv
/*
  spi pin sampler
  brings clk, cs and mosi into the system clock and flags edges and frame end
*/
`timescale 1ns/1ps
`default_nettype none

module spi_sampler #(
  parameter int SYNC_STAGES = 2
) (
  input  logic clk,
  input  logic rst_n,
  input  logic spi_clk,
  input  logic spi_cs,
  input  logic spi_mosi,
  output logic sclk_rise,
  output logic sclk_fall,
  output logic frame_end,
  output logic cs_active,
  output logic mosi_s
);

  // synchronizer chains, oldest sample at the top bit
  logic [SYNC_STAGES-1:0] clk_sync;
  logic [SYNC_STAGES-1:0] cs_sync;
  logic [SYNC_STAGES-1:0] mosi_sync;
  logic clk_s;
  logic cs_s;
  // held copies for edge detect
  logic clk_q;
  logic cs_q;

  assign clk_s = clk_sync[SYNC_STAGES-1];
  assign cs_s  = cs_sync[SYNC_STAGES-1];

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      clk_sync  <= '0;
      // cs idles high, so come out of reset deasserted
      cs_sync   <= '1;
      mosi_sync <= '0;
      clk_q     <= 1'b0;
      cs_q      <= 1'b1;
      sclk_rise <= 1'b0;
      sclk_fall <= 1'b0;
      frame_end <= 1'b0;
      cs_active <= 1'b0;
      mosi_s    <= 1'b0;
    end
    else
    begin
      clk_sync  <= {clk_sync[SYNC_STAGES-2:0], spi_clk};
      cs_sync   <= {cs_sync[SYNC_STAGES-2:0], spi_cs};
      mosi_sync <= {mosi_sync[SYNC_STAGES-2:0], spi_mosi};
      clk_q     <= clk_s;
      cs_q      <= cs_s;
      // clock edges only count inside a frame
      sclk_rise <= ~cs_s & clk_s & ~clk_q;
      sclk_fall <= ~cs_s & ~clk_s & clk_q;
      // cs rising ends the frame
      frame_end <= cs_s & ~cs_q;
      cs_active <= ~cs_s;
      mosi_s    <= mosi_sync[SYNC_STAGES-1];
    end
  end

endmodule

`default_nettype wire

// File: source/register_bank.sv
/*
  spi register bank
  40 bit frames carry the write flag and address in the first byte and 32 data bits after it
  readback of the addressed register is shifted out during the data phase
*/
`timescale 1ns/1ps
`default_nettype none

module register_bank (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                sclk_rise,
  input  logic                                sclk_fall,
  input  logic                                frame_end,
  input  logic                                cs_active,
  input  logic                                mosi_s,
  output logic                                reg_miso,
  output logic                                led,
  output logic [7:0]                          spi_mux_sel,
  output logic                                oe_4094,
  output logic [sense_ctl_pkg::MODE_BITS-1:0] mode,
  output logic [sense_ctl_pkg::COND_BITS-1:0] direct
);

  localparam int FRAME_BITS = sense_ctl_pkg::FRAME_BITS;
  localparam int REG_BITS   = sense_ctl_pkg::REG_BITS;
  localparam int ADDR_BITS  = sense_ctl_pkg::ADDR_BITS;
  // saturating counter needs one code past the frame length
  localparam int CNT_BITS   = $clog2(FRAME_BITS + 1);

  logic [CNT_BITS-1:0]   bit_cnt;
  logic [FRAME_BITS-1:0] shift_in;
  logic [REG_BITS-1:0]   out_shift;
  logic                  out_bit;

  // control registers
  logic [REG_BITS-1:0] reg_led;
  logic [REG_BITS-1:0] reg_spi_mux;
  logic [REG_BITS-1:0] reg_4094;
  logic [REG_BITS-1:0] reg_mode;
  logic [REG_BITS-1:0] reg_direct;

  // header fields of a finished frame
  logic                 wr_flag;
  logic [ADDR_BITS-1:0] wr_addr;
  logic [REG_BITS-1:0]  wr_data;
  logic                 frame_ok;

  // address as it completes with the 8th bit
  logic [ADDR_BITS-1:0] rd_addr;
  logic [REG_BITS-1:0]  rd_data;
  logic                 rd_load;

  assign wr_flag  = shift_in[FRAME_BITS-1];
  assign wr_addr  = shift_in[FRAME_BITS-2 -: ADDR_BITS];
  assign wr_data  = shift_in[REG_BITS-1:0];
  assign frame_ok = frame_end & (bit_cnt == CNT_BITS'(FRAME_BITS)) & wr_flag;

  assign rd_addr = {shift_in[ADDR_BITS-2:0], mosi_s};
  assign rd_load = sclk_rise & cs_active & (bit_cnt == CNT_BITS'(ADDR_BITS));

  // readback mux where unknown addresses read zero
  always_comb
  begin
    case (rd_addr)
      sense_ctl_pkg::ADDR_LED:     rd_data = reg_led;
      sense_ctl_pkg::ADDR_SPI_MUX: rd_data = reg_spi_mux;
      sense_ctl_pkg::ADDR_4094:    rd_data = reg_4094;
      sense_ctl_pkg::ADDR_MODE:    rd_data = reg_mode;
      sense_ctl_pkg::ADDR_DIRECT:  rd_data = reg_direct;
      default:                     rd_data = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // frame receive

  // mosi shifts in msb first
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      shift_in <= '0;
    else if (sclk_rise && cs_active)
      shift_in <= {shift_in[FRAME_BITS-2:0], mosi_s};
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      bit_cnt <= '0;
    else if (frame_end)
      bit_cnt <= '0;
    else if (sclk_rise && cs_active && bit_cnt != '1)
      bit_cnt <= bit_cnt + 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // only complete 40 bit write frames land in the registers

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      reg_led     <= '0;
      reg_spi_mux <= '0;
      reg_4094    <= '0;
      reg_mode    <= '0;
      reg_direct  <= '0;
    end
    else if (frame_ok)
    begin
      case (wr_addr)
        sense_ctl_pkg::ADDR_LED:     reg_led     <= wr_data;
        sense_ctl_pkg::ADDR_SPI_MUX: reg_spi_mux <= wr_data;
        sense_ctl_pkg::ADDR_4094:    reg_4094    <= wr_data;
        sense_ctl_pkg::ADDR_MODE:    reg_mode    <= wr_data;
        sense_ctl_pkg::ADDR_DIRECT:  reg_direct  <= wr_data;
        default:                     ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // readback shifter changes data on the falling edge for spi mode 0

  always_ff @(posedge clk)
  begin
    if (!rst_n || frame_end)
    begin
      out_shift <= '0;
      out_bit   <= 1'b0;
    end
    else if (rd_load)
      out_shift <= rd_data;
    else if (sclk_fall)
    begin
      // msb goes out on the fall before the first data rise
      out_bit   <= out_shift[REG_BITS-1];
      out_shift <= {out_shift[REG_BITS-2:0], 1'b0};
    end
  end

  assign reg_miso    = out_bit;
  // only the used bits leave the bank
  assign led         = reg_led[0];
  assign spi_mux_sel = reg_spi_mux[7:0];
  assign oe_4094     = reg_4094[0];
  assign mode        = reg_mode[sense_ctl_pkg::MODE_BITS-1:0];
  assign direct      = reg_direct[sense_ctl_pkg::COND_BITS-1:0];

endmodule

`default_nettype wire

// File: source/spi_router.sv
/*
  spi router
  passes the spi pins through to the 4094 chain on cs2 and picks the miso source
*/
`timescale 1ns/1ps
`default_nettype none

module spi_router (
  input  logic       spi_clk,
  input  logic       spi_mosi,
  input  logic       spi_cs,
  input  logic       spi_cs2,
  input  logic       u1004_4094_data,
  input  logic       reg_miso,
  input  logic [7:0] spi_mux_sel,
  output logic       glb_4094_clk,
  output logic       glb_4094_data,
  output logic       glb_4094_strobe,
  output logic       spi_miso
);

  // channel 0 of the mux select enables the 4094 chain while cs2 is low
  logic pass_4094;

  assign pass_4094 = spi_mux_sel[0] & ~spi_cs2;

  // everything held low when the chain is not selected
  assign glb_4094_clk    = pass_4094 & spi_clk;
  assign glb_4094_data   = pass_4094 & spi_mosi;
  // active high strobe for the 4094 while cs2 is low
  assign glb_4094_strobe = pass_4094;

  // chain readback wins over the register bank on miso
  always_comb
  begin
    if (!spi_cs2)
      spi_miso = u1004_4094_data;
    else if (!spi_cs)
      spi_miso = reg_miso;
    else
      spi_miso = 1'b0;
  end

endmodule

`default_nettype wire

// File: source/output_mode_select.sv
/*
  output mode select
  free running test pattern plus the registered mux that picks the
  conditioning word for the current mode
*/
`timescale 1ns/1ps
`default_nettype none

module output_mode_select (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [sense_ctl_pkg::MODE_BITS-1:0] mode,
  input  logic                                led,
  input  logic [sense_ctl_pkg::COND_BITS-1:0] direct,
  output sense_ctl_pkg::cond_word_t           cond
);

  localparam int COND_BITS = sense_ctl_pkg::COND_BITS;
  // led0 position in the word, matches cond_fields_t
  localparam int LED0_IDX  = 13;

  logic [COND_BITS-1:0]      pattern_cnt;
  sense_ctl_pkg::cond_word_t cond_nxt;

  ////////////////////////////////////////////////////////////
  // test pattern

  // wraps at 2^29, every pin toggles at its own rate
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      pattern_cnt <= '0;
    else
      pattern_cnt <= pattern_cnt + 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // mode mux

  always_comb
  begin
    cond_nxt.raw = '0;
    case (mode)
      // everything off, led under mcu control
      sense_ctl_pkg::MODE_LED_ONLY:
        cond_nxt.raw[LED0_IDX] = led;
      sense_ctl_pkg::MODE_ALL_ONES:
        cond_nxt.raw = '1;
      sense_ctl_pkg::MODE_PATTERN:
        cond_nxt.raw = pattern_cnt;
      // mcu drives every pin
      sense_ctl_pkg::MODE_DIRECT:
        cond_nxt.raw = direct;
      // modes 4 to 7 are spare, all low
      default:
        cond_nxt.raw = '0;
    endcase
  end

  // one clk from mode, led or direct to the pins
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      cond <= '0;
    else
      cond <= cond_nxt;
  end

endmodule

`default_nettype wire

// File: source/sense_ctl_top.sv
/*
  sense controller top level
  spi register bank, 4094 pass through and mode driven conditioning pins
*/
`timescale 1ns/1ps
`default_nettype none

module sense_ctl_top #(
  parameter int SYNC_STAGES = 2
) (
  input  logic       clk,
  input  logic       rst_n,
  // spi from the mcu
  input  logic       spi_clk,
  input  logic       spi_cs,
  input  logic       spi_cs2,
  input  logic       spi_mosi,
  input  logic       u1004_4094_data,
  output logic       spi_miso,
  // 4094 chain
  output logic       oe_4094,
  output logic       glb_4094_clk,
  output logic       glb_4094_data,
  output logic       glb_4094_strobe,
  // conditioning pins
  output logic [3:0] azmux,
  output logic [3:0] himux,
  output logic [3:0] himux2,
  output logic       sig_pc_sw_ctl,
  output logic       led0,
  output logic [7:0] monitor,
  output logic [3:0] adcmux,
  output logic       cmpr_latch_ctl,
  output logic       meas_complete_ctl,
  output logic       spi_interrupt_ctl
);

  // sampled spi
  logic sclk_rise;
  logic sclk_fall;
  logic frame_end;
  logic cs_active;
  logic mosi_s;

  // register bank outputs
  logic                                reg_miso;
  logic                                led;
  logic [7:0]                          spi_mux_sel;
  logic [sense_ctl_pkg::MODE_BITS-1:0] mode;
  logic [sense_ctl_pkg::COND_BITS-1:0] direct;

  sense_ctl_pkg::cond_word_t cond;

  spi_sampler #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_spi_sampler (
    .clk       (clk),
    .rst_n     (rst_n),
    .spi_clk   (spi_clk),
    .spi_cs    (spi_cs),
    .spi_mosi  (spi_mosi),
    .sclk_rise (sclk_rise),
    .sclk_fall (sclk_fall),
    .frame_end (frame_end),
    .cs_active (cs_active),
    .mosi_s    (mosi_s)
  );

  register_bank u_register_bank (
    .clk         (clk),
    .rst_n       (rst_n),
    .sclk_rise   (sclk_rise),
    .sclk_fall   (sclk_fall),
    .frame_end   (frame_end),
    .cs_active   (cs_active),
    .mosi_s      (mosi_s),
    .reg_miso    (reg_miso),
    .led         (led),
    .spi_mux_sel (spi_mux_sel),
    // output enable straight to the pin, low until the mcu enables it
    .oe_4094     (oe_4094),
    .mode        (mode),
    .direct      (direct)
  );

  spi_router u_spi_router (
    .spi_clk         (spi_clk),
    .spi_mosi        (spi_mosi),
    .spi_cs          (spi_cs),
    .spi_cs2         (spi_cs2),
    .u1004_4094_data (u1004_4094_data),
    .reg_miso        (reg_miso),
    .spi_mux_sel     (spi_mux_sel),
    .glb_4094_clk    (glb_4094_clk),
    .glb_4094_data   (glb_4094_data),
    .glb_4094_strobe (glb_4094_strobe),
    .spi_miso        (spi_miso)
  );

  output_mode_select u_output_mode_select (
    .clk    (clk),
    .rst_n  (rst_n),
    .mode   (mode),
    .led    (led),
    .direct (direct),
    .cond   (cond)
  );

  ////////////////////////////////////////////////////////////
  // break the conditioning word out into board pins

  assign azmux             = cond.f.azmux;
  assign himux             = cond.f.himux;
  assign himux2            = cond.f.himux2;
  assign sig_pc_sw_ctl     = cond.f.sig_pc_sw;
  assign led0              = cond.f.led0;
  assign monitor           = cond.f.monitor;
  assign adcmux            = cond.f.adcmux;
  assign cmpr_latch_ctl    = cond.f.cmpr_latch;
  assign meas_complete_ctl = cond.f.meas_complete;
  assign spi_interrupt_ctl = cond.f.spi_interrupt;

endmodule

`default_nettype wire

// File: sim/sense_ctl_tb.sv
/*
  sense controller testbench
  replays the spi trace against the top level and checks readback and pins
*/
`timescale 1ns/1ps
`default_nettype none

module sense_ctl_tb;

  localparam int HALF_CLKS = 8;
  localparam int TIMEOUT   = 2000;

  logic clk;
  logic rst_n;
  logic spi_clk;
  logic spi_cs;
  logic spi_cs2;
  logic spi_mosi;
  logic u1004_4094_data;
  logic spi_miso;
  logic oe_4094;
  logic glb_4094_clk;
  logic glb_4094_data;
  logic glb_4094_strobe;
  logic [3:0] azmux;
  logic [3:0] himux;
  logic [3:0] himux2;
  logic sig_pc_sw_ctl;
  logic led0;
  logic [7:0] monitor;
  logic [3:0] adcmux;
  logic cmpr_latch_ctl;
  logic meas_complete_ctl;
  logic spi_interrupt_ctl;
  // pins put back together with azmux at bit 0
  logic [28:0] pins_word;

  int errors;
  int tests;
  int failed;
  integer seed;

  assign pins_word = {spi_interrupt_ctl, meas_complete_ctl, cmpr_latch_ctl, adcmux,
                      monitor, led0, sig_pc_sw_ctl, himux2, himux, azmux};

  sense_ctl_top #(
    .SYNC_STAGES (2)
  ) DUT (
    .clk               (clk),
    .rst_n             (rst_n),
    .spi_clk           (spi_clk),
    .spi_cs            (spi_cs),
    .spi_cs2           (spi_cs2),
    .spi_mosi          (spi_mosi),
    .u1004_4094_data   (u1004_4094_data),
    .spi_miso          (spi_miso),
    .oe_4094           (oe_4094),
    .glb_4094_clk      (glb_4094_clk),
    .glb_4094_data     (glb_4094_data),
    .glb_4094_strobe   (glb_4094_strobe),
    .azmux             (azmux),
    .himux             (himux),
    .himux2            (himux2),
    .sig_pc_sw_ctl     (sig_pc_sw_ctl),
    .led0              (led0),
    .monitor           (monitor),
    .adcmux            (adcmux),
    .cmpr_latch_ctl    (cmpr_latch_ctl),
    .meas_complete_ctl (meas_complete_ctl),
    .spi_interrupt_ctl (spi_interrupt_ctl)
  );

  // 20 ns clock
  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // helpers

  // advance n clocks and land 2 ns after the rising edge
  task automatic step(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic report_mismatch(input logic [255:0] tname, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("[ERROR] %0s expected 0x%08h actual 0x%08h", tname, expected, actual);
    errors++;
  endtask

  // mode 0 frame with mosi set in the low half and miso taken just before each rise
  task automatic spi_frame(input logic [39:0] frame, input int nbits,
                           output logic [31:0] rx);
    int i;
    rx     = '0;
    spi_cs = 1'b0;
    for (i = 0; i < nbits; i++)
    begin
      spi_mosi = frame[39-i];
      step(HALF_CLKS);
      // data phase starts after the header byte
      if (i >= 8)
        rx = {rx[30:0], spi_miso};
      spi_clk = 1'b1;
      step(HALF_CLKS);
      spi_clk = 1'b0;
    end
    step(HALF_CLKS);
    spi_cs   = 1'b1;
    spi_mosi = 1'b0;
    // room for the register update
    step(HALF_CLKS);
  endtask

  // poll the pins until they match or the timeout runs out
  task automatic wait_pins(input logic [255:0] tname, input logic [28:0] expected);
    int cycles;
    cycles = 0;
    while (pins_word !== expected && cycles < TIMEOUT)
    begin
      step(1);
      cycles++;
    end
    if (pins_word !== expected)
      report_mismatch(tname, {3'b0, expected}, {3'b0, pins_word});
  endtask

  ////////////////////////////////////////////////////////////
  // trace replay

  initial
  begin
    integer fd;
    integer n;
    integer i;
    logic [8*128-1:0] line;
    logic [8*16-1:0] op;
    logic [255:0] tname;
    logic [31:0] addr;
    logic [31:0] value;
    logic [31:0] rx;
    logic [31:0] data;
    logic [28:0] first;
    logic [28:0] diff;
    logic [3:0] exp_route;
    int errors_before;

    rst_n           = 1'b0;
    spi_clk         = 1'b0;
    spi_cs          = 1'b1;
    spi_cs2         = 1'b1;
    spi_mosi        = 1'b0;
    u1004_4094_data = 1'b0;
    errors          = 0;
    tests           = 0;
    failed          = 0;
    seed            = 32'hdcf5b555;
    step(2);
    rst_n = 1'b1;
    step(1);

    fd = $fopen("sim/sense_ctl_trace.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the trace file sim/sense_ctl_trace.txt");
      errors++;
    end
    else
    begin
      while ($fgets(line, fd) != 0)
      begin
        n = $sscanf(line, "%s %s %h %h", op, tname, addr, value);
        // blank and comment lines carry no operation
        if (n == 4 && op != "#")
        begin
          errors_before = errors;
          if (op == "reset")
          begin
            rx = {oe_4094, glb_4094_strobe, spi_miso, pins_word};
            if (rx !== value)
              report_mismatch(tname, value, rx);
          end
          else if (op == "write")
            spi_frame({1'b1, addr[6:0], value}, 40, rx);
          // a write split into a 1 bit frame and a 39 bit frame must not land
          else if (op == "short")
          begin
            spi_frame({1'b1, 39'h0}, 1, rx);
            spi_frame({addr[6:0], value, 1'b0}, 39, rx);
          end
          else if (op == "read")
          begin
            spi_frame({1'b0, addr[6:0], 32'h0}, 40, rx);
            if (rx !== value)
              report_mismatch(tname, value, rx);
          end
          else if (op == "pins")
            wait_pins(tname, value[28:0]);
          // seeded data is read back and then seen on the pins in direct mode
          else if (op == "rand")
          begin
            data = $random(seed);
            spi_frame({1'b1, addr[6:0], data}, 40, rx);
            spi_frame({1'b0, addr[6:0], 32'h0}, 40, rx);
            if (rx !== data)
              report_mismatch(tname, data, rx);
            wait_pins(tname, data[28:0]);
          end
          // counter moves by exactly k in k clocks
          else if (op == "pattern")
          begin
            first = pins_word;
            step(value);
            diff = pins_word - first;
            if (diff !== value[28:0])
              report_mismatch(tname, value, {3'b0, diff});
          end
          // walk clk, mosi and chain data through all combinations with cs2 low
          else if (op == "route")
          begin
            spi_cs2 = 1'b0;
            for (i = 0; i < 8; i++)
            begin
              spi_clk         = i[0];
              spi_mosi        = i[1];
              u1004_4094_data = i[2];
              #1;
              exp_route = {value[0] & i[0], value[0] & i[1], value[0], i[2]};
              if ({glb_4094_clk, glb_4094_data, glb_4094_strobe, spi_miso} !== exp_route)
                report_mismatch(tname, {28'h0, exp_route},
                  {28'h0, glb_4094_clk, glb_4094_data, glb_4094_strobe, spi_miso});
              step(1);
            end
            spi_cs2         = 1'b1;
            spi_clk         = 1'b0;
            spi_mosi        = 1'b0;
            u1004_4094_data = 1'b0;
            step(1);
          end
          else if (op == "oe")
          begin
            if (oe_4094 !== value[0])
              report_mismatch(tname, {31'h0, value[0]}, {31'h0, oe_4094});
          end
          else
          begin
            $display("unknown operation %0s in the trace", op);
            errors++;
          end
          tests++;
          if (errors == errors_before)
            $display("[PASS] %0s", tname);
          else
          begin
            $display("[FAIL] %0s", tname);
            failed++;
          end
        end
      end
      $fclose(fd);
    end

    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             tests, tests - failed, failed, errors);
    if (errors == 0 && tests > 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/sense_ctl_trace.txt
# op test addr value, address and value in hex
# write and short send frames, the rest check readback, pins or the 4094 outputs
reset   after_reset   00 00000000
write   led_wr        07 deadbeef
read    led_rd        07 deadbeef
write   mux_wr        08 0badf00d
read    mux_rd        08 0badf00d
write   oe_wr         09 87654320
read    oe_rd         09 87654320
oe      oe_low        00 00000000
write   mode_wr       0c a5a5a5a4
read    mode_rd       0c a5a5a5a4
pins    mode4_zero    00 00000000
write   direct_wr     0e f2345678
read    direct_rd     0e f2345678
short   direct_short  0e 00000000
read    direct_kept   0e f2345678
read    unknown_rd    05 00000000
write   mode3         0c 00000003
pins    direct_pins   00 12345678
rand    direct_rand   0e 00000000
write   mode1         0c 00000001
pins    all_ones      00 1fffffff
write   mode0         0c 00000000
pins    led_on        00 00002000
write   led_off       07 fffffffe
pins    led_off_pins  00 00000000
write   mode2         0c 00000002
pattern pattern_step  00 00000011
write   mux_off       08 00000000
route   route_off     00 00000000
write   mux_on        08 00000001
route   route_on      00 00000001
write   oe_en         09 00000001
oe      oe_high       00 00000001

// File: sense_ctl.f
source/sense_ctl_pkg.sv
source/spi_sampler.sv
source/register_bank.sv
source/spi_router.sv
source/output_mode_select.sv
source/sense_ctl_top.sv
sim/sense_ctl_tb.sv
